//--- rtl/mbu_pkg.sv
package mbu_pkg;

   ////////////////////
   // Sizes and constants
   ////////////////////

   // Eight bank registers. 0 is MBP, 1 is MBD, 2 is MBS and 3 to 7 are general
   localparam int MBU_REGS = 8;

   // Width of a bank register index
   localparam int IDX_W = $clog2(MBU_REGS);

   // I/O window of the unit, 0x08 to 0x0F
   // Only the upper five address bits take part in the decode
   localparam logic [7:0] IO_BASE = 8'h08;

   // Extended address shown while the unit is still disabled
   localparam logic [7:0] AEXT_RAM_BOOT = 8'h00;
   localparam logic [7:0] AEXT_ROM_BOOT = 8'h80;

   ////////////////////
   // Micro-addresses
   ////////////////////

   // Write micro-addresses the unit decodes
   // The four address-register loads share the upper three bits 001,
   // so the low two bits pick MBP, MBD, MBS or the indexed bank
   typedef enum logic [4:0] {
      WA_AR_MBP    = 5'd4,
      WA_AR_MBD    = 5'd5,
      WA_AR_MBS    = 5'd6,
      WA_AR_IDX    = 5'd7,
      WA_MBP       = 5'd12,
      WA_MBP_FLAGS = 5'd13
   } cu_waddr_e;

   // Read micro-address that puts MBP on the internal bus
   typedef enum logic [4:0] {
      RA_MBP_FLAGS = 5'd13
   } cu_raddr_e;

   ////////////////////
   // Control encodings
   ////////////////////

   // Source of the read index, and so of aext
   typedef enum logic [1:0] {
      RD_MBP,
      RD_INDEX,
      RD_BUS
   } rd_src_e;

   // Source of the data written into the register file
   typedef enum logic [1:0] {
      WR_NONE,
      WR_CU,
      WR_BUS
   } wr_src_e;

   // Wishbone slave state
   typedef enum logic {
      ST_IDLE,
      ST_ACK
   } ack_state_e;

   ////////////////////
   // Bundles
   ////////////////////

   // Micro-operation request from the control unit
   // The address fields are plain vectors since any other code may show up
   typedef struct packed {
      logic       strobe;
      logic [4:0] raddr;
      logic [4:0] waddr;
      logic [2:0] ir;
      logic       ir_idx;
   } cu_req_t;

   // Wishbone classic master signals
   typedef struct packed {
      logic       cyc;
      logic       stb;
      logic       we;
      logic [7:0] adr;
      logic [7:0] dat;
   } wb_req_t;

   // Decisions passed from the control module to the datapath
   typedef struct packed {
      rd_src_e rd_src;
      wr_src_e wr_src;
      logic    enabled;
      logic    idx_armed;
      logic    capture;
   } mbu_ctl_t;

endpackage

//--- rtl/mbu_ctrl.sv
module mbu_ctrl
   import mbu_pkg::*;
(
   input  logic     clk,
   input  logic     rst_n,
   input  cu_req_t  cu,
   input  wb_req_t  wb,
   output mbu_ctl_t ctl,
   output logic     ar_load,
   output logic     ibus_oe,
   output logic     wb_ack,
   output logic     wb_err
);

   ack_state_e state;
   ack_state_e state_nxt;

   // Enable flag and the auto-index request from the last strobe
   logic enabled;
   logic idx_armed;

   logic cu_rmbp;
   logic cu_ar;
   logic cu_wmbp;
   logic wb_req;
   logic wb_hit;
   logic bus_read;
   logic stall;
   logic done;
   logic commit;

   ////////////////////
   // Micro-op decode
   ////////////////////

   // Read MBP onto the internal bus
   assign cu_rmbp = cu.strobe && (cu.raddr == RA_MBP_FLAGS);

   // Load the address register from one of the banks
   assign cu_ar = cu.strobe &&
                  (cu.waddr inside {WA_AR_MBP, WA_AR_MBD, WA_AR_MBS, WA_AR_IDX});

   // Write MBP from the internal bus
   assign cu_wmbp = cu.strobe && (cu.waddr inside {WA_MBP, WA_MBP_FLAGS});

   // The bus driver is only enabled for the read-MBP micro-op
   assign ibus_oe = cu_rmbp;

   // A read of MBP owns the read port, so it hides an AR load in the same cycle
   assign ar_load = cu_ar && !cu_rmbp;

   ////////////////////
   // Wishbone decode
   ////////////////////

   assign wb_req = wb.cyc && wb.stb;

   // Upper five bits select the eight-byte I/O window
   assign wb_hit = (wb.adr[7:3] == IO_BASE[7:3]);

   // A read to the window being served in this cycle
   assign bus_read = (state == ST_ACK) && wb_req && wb_hit && !wb.we;

   // Control-unit micro-ops win over the bus
   // A CU write blocks any access, and a CU read blocks a bus read
   // because both need the single read port
   assign stall = cu_wmbp || (bus_read && (cu_rmbp || cu_ar));

   // The access finishes in this cycle and its response shows up next cycle
   assign done = (state == ST_ACK) && wb_req && !stall;

   // Bus write that lands in the register file at the end of this cycle
   assign commit = done && wb_hit && wb.we;

   ////////////////////
   // Datapath control
   ////////////////////

   always_comb begin
      // At rest aext follows MBP
      ctl.rd_src = RD_MBP;
      if (cu_rmbp) begin
         ctl.rd_src = RD_MBP;
      end else if (cu_ar) begin
         ctl.rd_src = RD_INDEX;
      end else if (bus_read) begin
         ctl.rd_src = RD_BUS;
      end

      // The stall keeps a bus write away from a CU write in the same cycle
      ctl.wr_src = WR_NONE;
      if (cu_wmbp) begin
         ctl.wr_src = WR_CU;
      end else if (commit) begin
         ctl.wr_src = WR_BUS;
      end

      ctl.enabled   = enabled;
      ctl.idx_armed = idx_armed;

      // Sample aext for the bus only on a read that is about to be acknowledged
      ctl.capture = done && wb_hit && !wb.we;
   end

   ////////////////////
   // Ack state machine
   ////////////////////

   always_comb begin
      state_nxt = state;
      case (state)
         ST_IDLE: begin
            // While ack or err is out the master still holds stb for this cycle
            if (wb_req && !wb_ack && !wb_err) begin
               state_nxt = ST_ACK;
            end
         end
         ST_ACK: begin
            // Stay here while stalled, and give up if the master aborts
            if (!wb_req || !stall) begin
               state_nxt = ST_IDLE;
            end
         end
         default: begin
            state_nxt = ST_IDLE;
         end
      endcase
   end

   always_ff @(posedge clk) begin
      if (!rst_n) begin
         state     <= ST_IDLE;
         wb_ack    <= 1'b0;
         wb_err    <= 1'b0;
         enabled   <= 1'b0;
         idx_armed <= 1'b0;
      end else begin
         state  <= state_nxt;
         wb_ack <= done && wb_hit;
         wb_err <= done && !wb_hit;
         // Once on the unit stays on until the next reset
         if (commit) begin
            enabled <= 1'b1;
         end
         // Every strobe rewrites the auto-index request
         if (cu.strobe) begin
            idx_armed <= cu.ir_idx;
         end
      end
   end

endmodule

//--- rtl/mbu_addr_sel.sv
module mbu_addr_sel
   import mbu_pkg::*;
(
   input  mbu_ctl_t         ctl,
   input  cu_req_t          cu,
   input  logic [7:0]       wb_adr,
   output logic [IDX_W-1:0] rd_idx,
   output logic [IDX_W-1:0] wr_idx
);

   // Output of the first read mux stage
   logic [IDX_W-1:0] ar_idx;

   // Auto-indexing is only taken on the indexed AR load
   logic use_ir;

   ////////////////////
   // Read index
   ////////////////////

   assign use_ir = ctl.idx_armed && (cu.waddr == WA_AR_IDX);

   // First stage picks IR or the low two bits of the write micro-address
   // An unarmed WA_AR_IDX therefore falls on register 3
   always_comb begin
      if (use_ir) begin
         ar_idx = cu.ir;
      end else begin
         ar_idx = {1'b0, cu.waddr[1:0]};
      end
   end

   // Second stage picks between AR indexing, MBP and the bus address
   always_comb begin
      case (ctl.rd_src)
         RD_INDEX: rd_idx = ar_idx;
         RD_BUS:   rd_idx = wb_adr[IDX_W-1:0];
         default:  rd_idx = '0;
      endcase
   end

   ////////////////////
   // Write index
   ////////////////////

   // CU writes always go to MBP, bus writes use the low address bits
   always_comb begin
      case (ctl.wr_src)
         WR_BUS:  wr_idx = wb_adr[IDX_W-1:0];
         default: wr_idx = '0;
      endcase
   end

endmodule

//--- rtl/mbu_bank_regs.sv
module mbu_bank_regs
   import mbu_pkg::*;
(
   input  logic             clk,
   input  logic             rst_n,
   input  mbu_ctl_t         ctl,
   input  logic [IDX_W-1:0] rd_idx,
   input  logic [IDX_W-1:0] wr_idx,
   input  logic [7:0]       ibus_in,
   input  logic [7:0]       wb_dat,
   input  logic             rom_boot,
   output logic [7:0]       aext,
   output logic [7:0]       ibus_out,
   output logic [7:0]       wb_dat_r
);

   // The bank register file
   logic [7:0] regs [MBU_REGS];

   // Data selected for the write port
   logic [7:0] wr_data;

   ////////////////////
   // Write port
   ////////////////////

   assign wr_data = (ctl.wr_src == WR_BUS) ? wb_dat : ibus_in;

   // The bank registers start out cleared after reset
   always_ff @(posedge clk) begin
      if (!rst_n) begin
         for (int i = 0; i < MBU_REGS; i++) begin
            regs[i] <= 8'h00;
         end
      end else if (ctl.wr_src != WR_NONE) begin
         regs[wr_idx] <= wr_data;
      end
   end

   ////////////////////
   // Read port
   ////////////////////

   // Until the first bus write the bank comes from the front panel switch
   always_comb begin
      if (ctl.enabled) begin
         aext = regs[rd_idx];
      end else if (rom_boot) begin
         aext = AEXT_ROM_BOOT;
      end else begin
         aext = AEXT_RAM_BOOT;
      end
   end

   // The internal bus sees the same value, qualified by ibus_oe
   assign ibus_out = aext;

   // Hold the read data for the cycle in which ack is raised
   always_ff @(posedge clk) begin
      if (ctl.capture) begin
         wb_dat_r <= aext;
      end
   end

endmodule

//--- rtl/mbu_top.sv
module mbu_top
   import mbu_pkg::*;
(
   input  logic       clk,
   input  logic       rst_n,
   // Control unit side
   input  cu_req_t    cu,
   input  logic [7:0] ibus_in,
   output logic [7:0] ibus_out,
   output logic       ibus_oe,
   output logic       ar_load,
   // Programmed I/O over Wishbone
   input  wb_req_t    wb,
   output logic [7:0] wb_dat_r,
   output logic       wb_ack,
   output logic       wb_err,
   // Front panel and memory side
   input  logic       rom_boot,
   output logic [7:0] aext
);

   mbu_ctl_t         ctl;
   logic [IDX_W-1:0] rd_idx;
   logic [IDX_W-1:0] wr_idx;

   ////////////////////
   // Control
   ////////////////////

   // Decodes both masters and arbitrates the register file
   mbu_ctrl u_ctrl (
      .clk     (clk),
      .rst_n   (rst_n),
      .cu      (cu),
      .wb      (wb),
      .ctl     (ctl),
      .ar_load (ar_load),
      .ibus_oe (ibus_oe),
      .wb_ack  (wb_ack),
      .wb_err  (wb_err)
   );

   ////////////////////
   // Datapath
   ////////////////////

   // Index multiplexers for the read and write ports
   mbu_addr_sel u_addr_sel (
      .ctl    (ctl),
      .cu     (cu),
      .wb_adr (wb.adr),
      .rd_idx (rd_idx),
      .wr_idx (wr_idx)
   );

   // Register file with the aext output stage
   mbu_bank_regs u_bank_regs (
      .clk      (clk),
      .rst_n    (rst_n),
      .ctl      (ctl),
      .rd_idx   (rd_idx),
      .wr_idx   (wr_idx),
      .ibus_in  (ibus_in),
      .wb_dat   (wb.dat),
      .rom_boot (rom_boot),
      .aext     (aext),
      .ibus_out (ibus_out),
      .wb_dat_r (wb_dat_r)
   );

endmodule

//--- bench/mbu_tb_vectors.svh
`ifndef MBU_TB_VECTORS_SVH
`define MBU_TB_VECTORS_SVH

// Kinds of operation that one table row performs
// OP_REST only drives rom_boot and looks at aext with no master active
typedef enum logic [2:0] {
   OP_REST,
   OP_CU_WRITE,
   OP_CU_READ,
   OP_AR_LOAD,
   OP_WB_WRITE,
   OP_WB_READ
} op_kind_e;

// One row of the stimulus table
// uaddr is the raddr for OP_CU_READ and the waddr for the other control-unit kinds
// collide adds a WA_MBP strobe in the cycle after the bus request is seen
typedef struct packed {
   op_kind_e   op;
   logic [4:0] uaddr;
   logic [7:0] adr;
   logic [7:0] data;
   logic [2:0] ir;
   logic       ir_idx;
   logic       rom_boot;
   logic       collide;
   logic [7:0] exp_val;
} vec_t;

localparam int N_VECS = 29;

vec_t vecs [N_VECS];

task automatic load_vectors();
   // Columns: op, uaddr, adr, data, ir, ir_idx, rom_boot, collide, exp_val
   // Power-on default, then the first bus write turns the unit on
   vecs[0]  = '{OP_REST,     5'd0,         8'h00, 8'h00, 3'd0, 1'b0, 1'b0, 1'b0, 8'h00};
   vecs[1]  = '{OP_REST,     5'd0,         8'h00, 8'h00, 3'd0, 1'b0, 1'b1, 1'b0, 8'h80};
   vecs[2]  = '{OP_WB_READ,  5'd0,         8'h0B, 8'h00, 3'd0, 1'b0, 1'b1, 1'b0, 8'h80};
   vecs[3]  = '{OP_WB_READ,  5'd0,         8'h0B, 8'h00, 3'd0, 1'b0, 1'b0, 1'b0, 8'h00};
   vecs[4]  = '{OP_WB_WRITE, 5'd0,         8'h0D, 8'h3C, 3'd0, 1'b0, 1'b0, 1'b0, 8'h00};
   vecs[5]  = '{OP_REST,     5'd0,         8'h00, 8'h00, 3'd0, 1'b0, 1'b1, 1'b0, 8'h00};
   vecs[6]  = '{OP_WB_READ,  5'd0,         8'h0D, 8'h00, 3'd0, 1'b0, 1'b0, 1'b0, 8'h3C};
   // MBP written by the control unit and read back on both buses
   vecs[7]  = '{OP_CU_WRITE, WA_MBP,       8'h00, 8'h5A, 3'd0, 1'b0, 1'b0, 1'b0, 8'h00};
   vecs[8]  = '{OP_CU_READ,  RA_MBP_FLAGS, 8'h00, 8'h00, 3'd0, 1'b0, 1'b0, 1'b0, 8'h5A};
   vecs[9]  = '{OP_WB_READ,  5'd0,         8'h08, 8'h00, 3'd0, 1'b0, 1'b0, 1'b0, 8'h5A};
   // Fixed-index address-register loads
   vecs[10] = '{OP_WB_WRITE, 5'd0,         8'h09, 8'h11, 3'd0, 1'b0, 1'b0, 1'b0, 8'h00};
   vecs[11] = '{OP_WB_WRITE, 5'd0,         8'h0A, 8'h22, 3'd0, 1'b0, 1'b0, 1'b0, 8'h00};
   vecs[12] = '{OP_AR_LOAD,  WA_AR_MBD,    8'h00, 8'h00, 3'd0, 1'b0, 1'b0, 1'b0, 8'h11};
   vecs[13] = '{OP_AR_LOAD,  WA_AR_MBS,    8'h00, 8'h00, 3'd0, 1'b0, 1'b0, 1'b0, 8'h22};
   // Auto-indexing from IR, armed and unarmed
   vecs[14] = '{OP_WB_WRITE, 5'd0,         8'h0E, 8'h66, 3'd0, 1'b0, 1'b0, 1'b0, 8'h00};
   vecs[15] = '{OP_WB_WRITE, 5'd0,         8'h0B, 8'h33, 3'd0, 1'b0, 1'b0, 1'b0, 8'h00};
   vecs[16] = '{OP_AR_LOAD,  WA_AR_MBP,    8'h00, 8'h00, 3'd6, 1'b1, 1'b0, 1'b0, 8'h5A};
   vecs[17] = '{OP_AR_LOAD,  WA_AR_IDX,    8'h00, 8'h00, 3'd6, 1'b0, 1'b0, 1'b0, 8'h66};
   vecs[18] = '{OP_AR_LOAD,  WA_AR_IDX,    8'h00, 8'h00, 3'd6, 1'b0, 1'b0, 1'b0, 8'h33};
   // Misses outside the window must leave MBP alone
   vecs[19] = '{OP_WB_WRITE, 5'd0,         8'h20, 8'hFF, 3'd0, 1'b0, 1'b0, 1'b0, 8'h00};
   vecs[20] = '{OP_WB_READ,  5'd0,         8'h20, 8'h00, 3'd0, 1'b0, 1'b0, 1'b0, 8'h00};
   vecs[21] = '{OP_WB_READ,  5'd0,         8'h08, 8'h00, 3'd0, 1'b0, 1'b0, 1'b0, 8'h5A};
   vecs[22] = '{OP_REST,     5'd0,         8'h00, 8'h00, 3'd0, 1'b0, 1'b0, 1'b0, 8'h5A};
   // Bus write to MBP that collides with a control-unit MBP write
   vecs[23] = '{OP_WB_WRITE, 5'd0,         8'h08, 8'hC3, 3'd0, 1'b0, 1'b0, 1'b1, 8'h00};
   vecs[24] = '{OP_WB_READ,  5'd0,         8'h08, 8'h00, 3'd0, 1'b0, 1'b0, 1'b0, 8'hC3};
   vecs[25] = '{OP_CU_READ,  RA_MBP_FLAGS, 8'h00, 8'h00, 3'd0, 1'b0, 1'b0, 1'b0, 8'hC3};
   vecs[26] = '{OP_CU_WRITE, WA_MBP_FLAGS, 8'h00, 8'h7E, 3'd0, 1'b0, 1'b0, 1'b0, 8'h00};
   vecs[27] = '{OP_AR_LOAD,  WA_AR_MBP,    8'h00, 8'h00, 3'd0, 1'b0, 1'b0, 1'b0, 8'h7E};
   vecs[28] = '{OP_CU_READ,  5'd0,         8'h00, 8'h00, 3'd0, 1'b0, 1'b0, 1'b0, 8'h00};
endtask

`endif

//--- bench/mbu_tb.sv
module mbu_tb
   import mbu_pkg::*;
();

   localparam int CLK_PERIOD = 4;
   localparam int RST_CYCLES = 3;

   // Cycles a bus master waits for ack or err before it gives up
   localparam int WB_LIMIT = 8;

`include "mbu_tb_vectors.svh"

   // Twelve cycles per row leaves room for a stalled access and its timeout
   localparam int WATCHDOG_T = N_VECS * 12 * CLK_PERIOD + RST_CYCLES * CLK_PERIOD;

   logic       clk;
   logic       rst_n;
   cu_req_t    cu;
   logic [7:0] ibus_in;
   logic [7:0] ibus_out;
   logic       ibus_oe;
   logic       ar_load;
   wb_req_t    wb;
   logic [7:0] wb_dat_r;
   logic       wb_ack;
   logic       wb_err;
   logic       rom_boot;
   logic [7:0] aext;

   // Error count of the current row and the totals over the table
   int row_errs;
   int pass_rows;
   int fail_rows;

   mbu_top u_dut (
      .clk      (clk),
      .rst_n    (rst_n),
      .cu       (cu),
      .ibus_in  (ibus_in),
      .ibus_out (ibus_out),
      .ibus_oe  (ibus_oe),
      .ar_load  (ar_load),
      .wb       (wb),
      .wb_dat_r (wb_dat_r),
      .wb_ack   (wb_ack),
      .wb_err   (wb_err),
      .rom_boot (rom_boot),
      .aext     (aext)
   );

   initial begin
      clk = 1'b0;
      forever #(CLK_PERIOD / 2) clk = ~clk;
   end

   // Ends a run whose table never completes
   initial begin
      #(WATCHDOG_T);
      $display("Watchdog expired at t=%0t before the table was done", $time);
      $display("Simulation finished: FAIL");
      $finish;
   end

   //////////////////////
   // Helpers
   //////////////////////

   task automatic report_mismatch(input string sig, input logic [7:0] got,
                                  input logic [7:0] want);
      $display("FAILED t=%0t signal %s got 0x%h expected 0x%h", $time, sig, got, want);
      row_errs++;
   endtask

   // Raise a one-cycle strobe and return at the middle of that cycle,
   // where the combinational outputs of the micro-op are settled
   task automatic cu_strobe(input logic [4:0] raddr, input logic [4:0] waddr,
                            input logic [2:0] ir, input logic ir_idx,
                            input logic [7:0] data);
      cu_req_t op;
      op.strobe = 1'b1;
      op.raddr  = raddr;
      op.waddr  = waddr;
      op.ir     = ir;
      op.ir_idx = ir_idx;
      @(posedge clk);
      cu      <= op;
      ibus_in <= data;
      @(negedge clk);
   endtask

   // One Wishbone classic access, ended by ack or err or by the wait limit
   task automatic wb_access(input logic we, input logic [7:0] adr, input logic [7:0] dat,
                            input logic collide, output logic ack, output logic err,
                            output logic [7:0] rdata, output logic tmo);
      wb_req_t req;
      cu_req_t op;
      int      n;
      logic    got;
      req.cyc = 1'b1;
      req.stb = 1'b1;
      req.we  = we;
      req.adr = adr;
      req.dat = dat;
      @(posedge clk);
      wb <= req;
      // The MBP write lands in the cycle in which the slave would answer,
      // and its data is the complement so the two writers can be told apart
      if (collide) begin
         op        = '0;
         op.strobe = 1'b1;
         op.waddr  = WA_MBP;
         @(posedge clk);
         cu      <= op;
         ibus_in <= ~dat;
         @(posedge clk);
         cu <= '0;
      end
      n   = 0;
      got = 1'b0;
      while (!got && n < WB_LIMIT) begin
         @(negedge clk);
         if (wb_ack || wb_err) begin
            got = 1'b1;
         end else begin
            n++;
         end
      end
      ack   = wb_ack;
      err   = wb_err;
      rdata = wb_dat_r;
      tmo   = !got;
      // Classic bus: stb goes away after the response
      @(posedge clk);
      wb <= '0;
   endtask

   //////////////////////
   // Table loop
   //////////////////////

   initial begin
      vec_t       v;
      op_kind_e   kind;
      logic       ack;
      logic       err;
      logic       tmo;
      logic [7:0] rdata;
      logic       exp_hit;
      logic       exp_ar;
      logic       exp_oe;
      cu        = '0;
      ibus_in   = 8'h00;
      wb        = '0;
      rom_boot  = 1'b0;
      rst_n     = 1'b0;
      pass_rows = 0;
      fail_rows = 0;
      load_vectors();
      repeat (RST_CYCLES) @(posedge clk);
      rst_n <= 1'b1;

      for (int i = 0; i < N_VECS; i++) begin
         v        = vecs[i];
         kind     = v.op;
         row_errs = 0;
         // The window is 0x08 to 0x0F, so the upper five address bits are 00001
         exp_hit = (v.adr[7:3] == 5'b00001);
         // AR loads are the write micro-addresses 4 to 7
         exp_ar = (v.uaddr >= 5'd4) && (v.uaddr <= 5'd7);
         exp_oe = (v.uaddr == 5'd13);
         @(posedge clk);
         rom_boot <= v.rom_boot;
         case (kind)
            OP_REST: begin
               @(negedge clk);
               if (aext !== v.exp_val)
                  report_mismatch("aext", aext, v.exp_val);
               if (ibus_oe !== 1'b0)
                  report_mismatch("ibus_oe", 8'(ibus_oe), 8'h00);
               if (ar_load !== 1'b0)
                  report_mismatch("ar_load", 8'(ar_load), 8'h00);
            end
            OP_CU_WRITE: begin
               cu_strobe(5'd0, v.uaddr, v.ir, v.ir_idx, v.data);
               if (ibus_oe !== 1'b0)
                  report_mismatch("ibus_oe", 8'(ibus_oe), 8'h00);
               if (ar_load !== 1'b0)
                  report_mismatch("ar_load", 8'(ar_load), 8'h00);
            end
            OP_CU_READ: begin
               cu_strobe(v.uaddr, 5'd0, v.ir, v.ir_idx, v.data);
               if (ibus_oe !== exp_oe)
                  report_mismatch("ibus_oe", 8'(ibus_oe), 8'(exp_oe));
               if (exp_oe && ibus_out !== v.exp_val)
                  report_mismatch("ibus_out", ibus_out, v.exp_val);
            end
            OP_AR_LOAD: begin
               cu_strobe(5'd0, v.uaddr, v.ir, v.ir_idx, v.data);
               if (ar_load !== exp_ar)
                  report_mismatch("ar_load", 8'(ar_load), 8'(exp_ar));
               if (aext !== v.exp_val)
                  report_mismatch("aext", aext, v.exp_val);
            end
            default: begin
               wb_access(kind == OP_WB_WRITE, v.adr, v.data, v.collide,
                         ack, err, rdata, tmo);
               if (tmo) begin
                  $display("Wishbone access to 0x%h at t=%0t got neither ack nor err in %0d cycles",
                           v.adr, $time, WB_LIMIT);
                  row_errs++;
               end else begin
                  if (ack !== exp_hit)
                     report_mismatch("wb_ack", 8'(ack), 8'(exp_hit));
                  if (err !== !exp_hit)
                     report_mismatch("wb_err", 8'(err), 8'(!exp_hit));
                  if (kind == OP_WB_READ && exp_hit && rdata !== v.exp_val)
                     report_mismatch("wb_dat_r", rdata, v.exp_val);
               end
            end
         endcase
         // Strobes last a single cycle
         @(posedge clk);
         cu <= '0;
         if (row_errs == 0) begin
            pass_rows++;
            $display("row %0d %s ok", i, kind.name());
         end else begin
            fail_rows++;
            $display("row %0d %s failed with %0d errors", i, kind.name(), row_errs);
         end
      end

      $display("rows %0d, passed %0d, failed %0d", N_VECS, pass_rows, fail_rows);
      if (fail_rows == 0) begin
         $display("Simulation finished: PASS");
      end else begin
         $display("Simulation finished: FAIL");
      end
      $finish;
   end

endmodule

//--- mbu_top.f
+incdir+bench
rtl/mbu_pkg.sv
rtl/mbu_ctrl.sv
rtl/mbu_addr_sel.sv
rtl/mbu_bank_regs.sv
rtl/mbu_top.sv
bench/mbu_tb.sv

//--- Makefile
TOP := mbu_tb
LOG := sim.log

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  help   list the targets"
	@echo "  test   build with Verilator, run the testbench and check $(LOG)"
	@echo "  clean  remove the build folder and $(LOG)"

test:
	verilator --binary --timing -f mbu_top.f --top-module $(TOP) -Mdir obj_dir
	./obj_dir/V$(TOP) | tee $(LOG)
	@if grep -q "Simulation finished: PASS" $(LOG); then \
		echo "test passed"; \
	else \
		echo "test failed"; \
		exit 1; \
	fi

clean:
	rm -rf obj_dir $(LOG)
